/* src.f */
design/snd_pkg.sv
design/snd_regs.sv
design/rom_arbiter.sv
design/pcm_player.sv
design/dc_remover.sv
design/snd_mixer.sv
design/snd_top.sv
verification/snd_props.sv
verification/tb_snd_top.sv

/* verification/tb_snd_top.sv */
/* Testbench for snd_top: AXI4-Lite host, ROM model with 1 to 4 cycles of latency,
   FM chip model with a strobe every 16 clocks. The checking lives in the bound snd_props. */
`timescale 1ns/100ps

module tb_snd_top;

    // roughly 2000 cycles of tests, ten times that as margin
    localparam int max_cycles = 20000;

    logic               clk, comb_rstn;
    snd_pkg::axi_addr_t awaddr, araddr;
    snd_pkg::axi_data_t wdata, rdata;
    logic [3:0]         wstrb;
    logic               awvalid, awready, wvalid, wready, bvalid, bready;
    logic               arvalid, arready, rvalid, rready;
    logic [1:0]         bresp, rresp;
    snd_pkg::rom_addr_t rom_addr;
    snd_pkg::rom_byte_t rom_data;
    logic               rom_cs, rom_ok;
    snd_pkg::audio_t    fm_snd, snd;
    snd_pkg::psg_t      psg_snd;
    logic               sample, peak, pcm_busy;
    logic [3:0]         strobe_cnt;
    int                 rom_wait, rom_lat, cycle_count, tb_errors;

    snd_top u_dut (.*);

    // code 5 points to 0x0400, eight bytes then the end marker
    function automatic snd_pkg::rom_byte_t rom_byte(input snd_pkg::rom_addr_t a);
        if (a == 16'h009a) return 8'h00;
        if (a == 16'h009b) return 8'h04;
        if (a >= 16'h0400 && a <= 16'h0407) return {a[2:0], 5'h11};
        if (a == 16'h0408) return 8'h00;
        return a[15:8] ^ a[7:0] ^ 8'h5c;
    endfunction

    task automatic check_word(input string what, input snd_pkg::axi_data_t got,
                              input snd_pkg::axi_data_t exp);
        assert (got == exp) else begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            tb_errors++;
        end
    endtask

    task automatic axi_write(input snd_pkg::axi_addr_t addr, input snd_pkg::axi_data_t data,
                             output logic [1:0] resp);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hf;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge clk); while (!awready);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        // late bready keeps bvalid waiting
        repeat ($urandom % 3) @(posedge clk);
        bready <= 1'b1;
        do @(posedge clk); while (!bvalid);
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axi_read(input snd_pkg::axi_addr_t addr, output snd_pkg::axi_data_t data,
                            output logic [1:0] resp);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        repeat ($urandom % 3) @(posedge clk);
        rready <= 1'b1;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic rom_window_read();
        snd_pkg::rom_addr_t a;
        snd_pkg::axi_data_t data;
        logic [1:0]         resp;
        a = 16'($urandom);
        axi_read(snd_pkg::rom_window_base | {4'h0, a}, data, resp);
        check_word("ROM window byte", data, {24'h0, rom_byte(a)});
    endtask

    task automatic wait_strobes(input int n);
        repeat (n) begin
            do @(posedge clk); while (!sample);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // FM chip: new random FM and PSG values with each strobe
    always @(posedge clk) begin
        strobe_cnt <= strobe_cnt + 4'd1;
        sample     <= strobe_cnt == 4'd15;
        if (strobe_cnt == 4'd15) begin
            fm_snd  <= 16'($urandom);
            psg_snd <= 10'($urandom);
        end
    end

    // ROM answers after rom_lat cycles, cs drops after ok
    always @(posedge clk) begin
        if (rom_ok || !rom_cs) begin
            rom_ok   <= 1'b0;
            rom_wait <= 0;
        end else if (rom_wait + 1 >= rom_lat) begin
            rom_ok   <= 1'b1;
            rom_data <= rom_byte(rom_addr);
            rom_lat  <= 1 + $urandom % 4;
        end else begin
            rom_wait <= rom_wait + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        logic [1:0]         resp;
        snd_pkg::axi_data_t data;
        int                 total;
        void'($urandom(32'hbaf4_83d8));
        comb_rstn = 1'b0;
        {awaddr, wdata, wstrb, awvalid, wvalid, bready} = '0;
        {araddr, arvalid, rready} = '0;
        {rom_data, rom_ok, fm_snd, psg_snd, sample} = '0;
        strobe_cnt  = '0;
        rom_wait    = 0;
        rom_lat     = 1;
        cycle_count = 0;
        tb_errors   = 0;
        repeat (8) @(posedge clk);
        comb_rstn <= 1'b1;
        wait_strobes(2);

        // every fx_level and enable combination, PCM off
        for (int v = 0; v < 16; v++) begin
            axi_write(snd_pkg::reg_ctrl, v, resp);
            check_word("ctrl write response", resp, snd_pkg::resp_okay);
            axi_read(snd_pkg::reg_ctrl, data, resp);
            check_word("ctrl readback", data, v);
            check_word("ctrl read response", resp, snd_pkg::resp_okay);
            wait_strobes(3);
        end

        axi_write(20'h0_000c, 32'h1234_5678, resp);
        check_word("unmapped write response", resp, snd_pkg::resp_slverr);
        // ctrl keeps the last loop value
        axi_read(snd_pkg::reg_ctrl, data, resp);
        check_word("ctrl after unmapped write", data, 32'h0000_000f);

        repeat (8) rom_window_read();

        // start code 5 and compete for the ROM while it plays
        axi_write(snd_pkg::reg_ctrl, 32'h1e, resp);
        axi_write(snd_pkg::reg_trigger, 32'd5, resp);
        check_word("trigger write response", resp, snd_pkg::resp_okay);
        repeat (4) rom_window_read();
        while (pcm_busy) @(posedge clk);
        wait_strobes(4);

        total = tb_errors + u_dut.u_props.fail_count;
        $display("errors: %0d assertion failures, %0d readback mismatches",
                 u_dut.u_props.fail_count, tb_errors);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verification/snd_props.sv */
/* Bound checker for the AXI4-Lite handshakes, the ROM port, the PCM fetch order and the mix.
   The PCM address tracker expects triggers to arrive while the player is idle. */
`timescale 1ns/100ps

module snd_props (
    input logic               clk,
    input logic               comb_rstn,
    input logic               awvalid,
    input logic               awready,
    input logic               wvalid,
    input logic               wready,
    input logic               bvalid,
    input logic               bready,
    input logic               rvalid,
    input logic               rready,
    input snd_pkg::axi_data_t rdata,
    input logic [1:0]         rresp,
    input snd_pkg::rom_addr_t rom_addr,
    input logic               rom_cs,
    input snd_pkg::rom_byte_t rom_data,
    input logic               rom_ok,
    input logic               host_ack,
    input logic               pcm_ack,
    input logic               trigger,
    input snd_pkg::pcm_code_t trigger_code,
    input logic               pcm_en,
    input logic               pcm_busy,
    input logic               sample,
    input logic [1:0]         fx_level,
    input logic               psg_en,
    input logic               fm_en,
    input snd_pkg::audio_t    fm_snd,
    input snd_pkg::psg_t      psg_snd,
    input logic signed [7:0]  pcm_centred,
    input snd_pkg::audio_t    snd,
    input logic               peak
);
    int                 fail_count = 0;
    int                 exp_sum;
    logic               exp_clip;
    snd_pkg::audio_t    exp_snd;
    // 0 pointer low, 1 pointer high, 2 playing, 3 idle
    logic [1:0]         pcm_stage;
    snd_pkg::rom_addr_t exp_pcm_addr;
    snd_pkg::rom_byte_t ptr_lo_seen;

    // weighted sum from the gain rules, before saturation
    function automatic int mix_expect(input logic [1:0] lvl, input logic p_en, input logic f_en,
                                      input logic c_en, input snd_pkg::audio_t fm,
                                      input snd_pkg::psg_t psg, input logic signed [7:0] pcm);
        int g_psg;
        int g_fm;
        int g_pcm;
        g_psg = p_en ? int'(snd_pkg::psg_gain_table[lvl]) : 0;
        g_fm  = f_en ? int'(c_en ? snd_pkg::fm_gain_with_pcm : snd_pkg::fm_gain_solo) : 0;
        g_pcm = c_en ? int'(snd_pkg::pcm_gain_on) : 0;
        return ((int'(fm) * g_fm) >>> 4) + (((int'(psg) - 512) * g_psg) >>> 4)
             + ((int'(pcm) * 256 * g_pcm) >>> 4);
    endfunction

    assign exp_sum  = mix_expect(fx_level, psg_en, fm_en, pcm_en, fm_snd, psg_snd, pcm_centred);
    assign exp_clip = exp_sum > 32767 || exp_sum < -32768;
    assign exp_snd  = exp_sum > 32767 ? 16'h7fff : exp_sum < -32768 ? 16'h8000 : 16'(exp_sum);

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            pcm_stage    <= 2'd3;
            exp_pcm_addr <= '0;
            ptr_lo_seen  <= '0;
        end else if (trigger && pcm_en) begin
            pcm_stage    <= 2'd0;
            exp_pcm_addr <= snd_pkg::ptr_table_base + 16'(2 * trigger_code);
        end else if (pcm_ack) begin
            case (pcm_stage)
                2'd0: begin
                    ptr_lo_seen  <= rom_data;
                    exp_pcm_addr <= exp_pcm_addr + 16'd1;
                    pcm_stage    <= 2'd1;
                end
                2'd1: begin
                    exp_pcm_addr <= {rom_data, ptr_lo_seen};
                    pcm_stage    <= 2'd2;
                end
                2'd2: begin
                    if (rom_data == 8'd0) begin
                        pcm_stage <= 2'd3;
                    end else begin
                        exp_pcm_addr <= exp_pcm_addr + 16'd1;
                    end
                end
                default: pcm_stage <= 2'd3;
            endcase
        end
    end

    // awready and wready pulse together while both channels are valid
    assert property (@(posedge clk) disable iff (!comb_rstn)
        (awready || wready) |-> (awready && wready && awvalid && wvalid)
        ##1 (!awready && !wready))
        else begin
            $error("Fail %0t: write handshake was not a single joint pulse", $time);
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!comb_rstn) bvalid && !bready |=> bvalid)
        else begin
            $error("Fail %0t: bvalid dropped before bready", $time);
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!comb_rstn)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            $error("Fail %0t: read response changed before rready", $time);
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!comb_rstn)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else begin
            $error("Fail %0t: rom_cs or rom_addr moved before rom_ok", $time);
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!comb_rstn)
        host_ack |=> rvalid && rdata == {24'h0, $past(rom_data)} && rresp == snd_pkg::resp_okay)
        else begin
            $error("Fail %0t: ROM window returned wrong data", $time);
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!comb_rstn) pcm_ack |-> rom_addr == exp_pcm_addr)
        else begin
            $error("Fail %0t: PCM fetch at %h, expected %h", $time, rom_addr, exp_pcm_addr);
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!comb_rstn) trigger && pcm_en |=> pcm_busy)
        else begin
            $error("Fail %0t: pcm_busy not set after trigger", $time);
            fail_count++;
        end

    // busy from the trigger until the end byte comes back
    assert property (@(posedge clk) disable iff (!comb_rstn)
        pcm_busy == (pcm_stage != 2'd3))
        else begin
            $error("Fail %0t: pcm_busy is %b in fetch stage %0d", $time, pcm_busy, pcm_stage);
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!comb_rstn)
        sample |=> snd == $past(exp_snd) && peak == $past(exp_clip))
        else begin
            $error("Fail %0t: mixer gave %h peak %b, expected %h peak %b", $time, snd, peak,
                   $past(exp_snd), $past(exp_clip));
            fail_count++;
        end

    assert property (@(posedge clk) $rose(comb_rstn) |-> snd == '0 && !peak)
        else begin
            $error("Fail %0t: output not muted after reset", $time);
            fail_count++;
        end

endmodule

bind snd_top snd_props u_props (.*);

/* design/snd_top.sv */
/* Sound subsystem top: AXI4-Lite registers, shared sample ROM port, PCM path and mixer.
   Channels start muted; the status peak bit is sticky until status is read. */
`timescale 1ns/100ps

module snd_top (
    input  logic               clk,
    input  logic               comb_rstn,
    // AXI4-Lite slave
    input  snd_pkg::axi_addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  snd_pkg::axi_data_t wdata,
    input  logic [3:0]         wstrb,
    input  logic               wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready,
    input  snd_pkg::axi_addr_t araddr,
    input  logic               arvalid,
    output logic               arready,
    output snd_pkg::axi_data_t rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  logic               rready,
    // sample ROM
    output snd_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    input  snd_pkg::rom_byte_t rom_data,
    input  logic               rom_ok,
    // FM chip
    input  snd_pkg::audio_t    fm_snd,
    input  snd_pkg::psg_t      psg_snd,
    input  logic               sample,
    output snd_pkg::audio_t    snd,
    output logic               peak,
    output logic               pcm_busy
);
    logic               host_req, host_ack, pcm_req, pcm_ack, trigger, pcm_tick;
    logic               psg_en, fm_en, pcm_en, peak_seen, status_rd;
    logic [1:0]         fx_level;
    logic signed [7:0]  pcm_centred;
    snd_pkg::rom_addr_t host_addr, pcm_addr_req, pcm_addr;
    snd_pkg::rom_byte_t rd_data, pcm_value;
    snd_pkg::pcm_code_t trigger_code;

    assign status_rd = arvalid & arready & (araddr == snd_pkg::reg_status);

    // a new clip wins over a status read in the same cycle
    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            peak_seen <= 1'b0;
        end else if (peak) begin
            peak_seen <= 1'b1;
        end else if (status_rd) begin
            peak_seen <= 1'b0;
        end
    end

    snd_regs    u_regs   (.*, .busy(pcm_busy));
    rom_arbiter u_arb    (.*);
    pcm_player  u_player (.*, .busy(pcm_busy));
    dc_remover  u_dcrm   (.*);
    snd_mixer   u_mixer  (.*);

endmodule

/* design/snd_mixer.sv */
/* FM, PSG and PCM mix with table gains, one result per sample strobe.
   snd saturates to 16 bits signed; peak marks the sample that clipped. */
`timescale 1ns/100ps

module snd_mixer (
    input  logic              clk,
    input  logic              comb_rstn,
    input  logic              sample,
    input  logic [1:0]        fx_level,
    input  logic              psg_en,
    input  logic              fm_en,
    input  logic              pcm_en,
    input  snd_pkg::audio_t   fm_snd,
    input  snd_pkg::psg_t     psg_snd,
    input  logic signed [7:0] pcm_centred,
    output snd_pkg::audio_t   snd,
    output logic              peak
);
    snd_pkg::gain_t     fm_gain, psg_gain, pcm_gain;
    logic signed [10:0] psg_c;
    logic signed [25:0] fm_term, psg_term, pcm_term, sum;
    logic               sat_hi, sat_lo;

    assign psg_gain = psg_en ? snd_pkg::psg_gain_table[fx_level] : '0;
    // FM is pulled down when PCM shares the mix
    assign fm_gain  = !fm_en ? '0 : pcm_en ? snd_pkg::fm_gain_with_pcm : snd_pkg::fm_gain_solo;
    assign pcm_gain = pcm_en ? snd_pkg::pcm_gain_on : '0;

    // psg is offset binary around 512
    assign psg_c = $signed({1'b0, psg_snd}) - 11'sd512;

    assign fm_term  = (fm_snd * $signed({1'b0, fm_gain})) >>> 4;
    assign psg_term = (psg_c * $signed({1'b0, psg_gain})) >>> 4;
    assign pcm_term = ($signed({pcm_centred, 8'h00}) * $signed({1'b0, pcm_gain})) >>> 4;
    assign sum      = fm_term + psg_term + pcm_term;
    assign sat_hi   = sum > 26'sd32767;
    assign sat_lo   = sum < -26'sd32768;

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            snd  <= '0;
            peak <= 1'b0;
        end else if (sample) begin
            peak <= sat_hi | sat_lo;
            if (sat_hi) begin
                snd <= 16'h7fff;
            end else if (sat_lo) begin
                snd <= 16'h8000;
            end else begin
                snd <= sum[15:0];
            end
        end
    end

endmodule

/* design/dc_remover.sv */
/* Leaky running mean (1/16 per tick) subtracted from the unsigned PCM byte.
   The output is saturated to 8 bits signed and only moves on pcm_tick. */
`timescale 1ns/100ps

module dc_remover (
    input  logic               clk,
    input  logic               comb_rstn,
    input  logic               pcm_tick,
    input  snd_pkg::rom_byte_t pcm_value,
    output logic signed [7:0]  pcm_centred
);
    // mean scaled by 16, settles at most at 255*16
    logic        [11:0] mean_fx;
    logic signed [9:0]  diff;

    assign diff = $signed({2'b00, pcm_value}) - $signed({2'b00, mean_fx[11:4]});

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            mean_fx     <= '0;
            pcm_centred <= '0;
        end else if (pcm_tick) begin
            mean_fx <= mean_fx - (mean_fx >> 4) + {4'h0, pcm_value};
            if (diff > 10'sd127) begin
                pcm_centred <= 8'sd127;
            end else if (diff < -10'sd128) begin
                pcm_centred <= -8'sd128;
            end else begin
                pcm_centred <= diff[7:0];
            end
        end
    end

endmodule

/* design/pcm_player.sv */
/* PCM sample player: pointer lookup, then one unsigned byte per pcm_tick.
   Stops on a zero byte or past 0xFFFF; triggers are ignored while pcm_en is low. */
`timescale 1ns/100ps

module pcm_player (
    input  logic               clk,
    input  logic               comb_rstn,
    input  logic               sample,
    input  logic               pcm_en,
    input  logic               trigger,
    input  snd_pkg::pcm_code_t trigger_code,
    output logic               pcm_req,
    output snd_pkg::rom_addr_t pcm_addr_req,
    input  logic               pcm_ack,
    input  snd_pkg::rom_byte_t rd_data,
    output logic               pcm_tick,
    output snd_pkg::rom_byte_t pcm_value,
    output logic               busy,
    output snd_pkg::rom_addr_t pcm_addr
);
    snd_pkg::pcm_state_t              st;
    snd_pkg::rom_addr_t               addr;
    snd_pkg::rom_byte_t               ptr_lsb;
    logic [snd_pkg::pcm_tick_div-1:0] phase;
    // set when a restart lands on a fetch still in flight
    logic                             discard;

    assign busy         = st != snd_pkg::idle;
    assign pcm_addr     = addr;
    assign pcm_addr_req = addr;

    // one-hot ring, ticks on every third strobe
    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            phase    <= 1;
            pcm_tick <= 1'b0;
        end else begin
            pcm_tick <= sample & phase[snd_pkg::pcm_tick_div-1];
            if (sample) begin
                phase <= {phase[snd_pkg::pcm_tick_div-2:0], phase[snd_pkg::pcm_tick_div-1]};
            end
        end
    end

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            st        <= snd_pkg::idle;
            addr      <= '0;
            ptr_lsb   <= '0;
            pcm_value <= '0;
            pcm_req   <= 1'b0;
            discard   <= 1'b0;
        end else begin
            if (pcm_ack && discard) begin
                discard <= 1'b0;
            end else if (pcm_ack) begin
                case (st)
                    snd_pkg::ptr_lo: begin
                        ptr_lsb <= rd_data;
                        addr    <= addr + 16'd1;
                        st      <= snd_pkg::ptr_hi;
                    end
                    snd_pkg::ptr_hi: begin
                        addr    <= {rd_data, ptr_lsb};
                        pcm_req <= 1'b0;
                        st      <= snd_pkg::play;
                    end
                    snd_pkg::play: begin
                        pcm_req <= 1'b0;
                        // zero only ends the sample, the last level is kept
                        if (rd_data != 8'd0) begin
                            pcm_value <= rd_data;
                        end
                        if (rd_data == 8'd0 || &addr) begin
                            st <= snd_pkg::idle;
                        end else begin
                            addr <= addr + 16'd1;
                        end
                    end
                    default: pcm_req <= 1'b0;
                endcase
            end else if (pcm_tick && st == snd_pkg::play && !pcm_req) begin
                pcm_req <= 1'b1;
            end
            if (trigger && pcm_en) begin
                st      <= snd_pkg::ptr_lo;
                addr    <= snd_pkg::ptr_table_base + {9'd0, trigger_code, 1'b0};
                pcm_req <= 1'b1;
                discard <= pcm_req & ~pcm_ack;
            end
        end
    end

endmodule

/* design/rom_arbiter.sv */
/* Shares the sample ROM port between the PCM player and the host window.
   PCM wins on a free port; cs and addr hold until ok, then one idle cycle follows. */
`timescale 1ns/100ps

module rom_arbiter (
    input  logic               clk,
    input  logic               comb_rstn,
    input  logic               pcm_req,
    input  snd_pkg::rom_addr_t pcm_addr_req,
    output logic               pcm_ack,
    input  logic               host_req,
    input  snd_pkg::rom_addr_t host_addr,
    output logic               host_ack,
    output snd_pkg::rom_byte_t rd_data,
    output snd_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    input  snd_pkg::rom_byte_t rom_data,
    input  logic               rom_ok
);
    // owner of the access in flight
    logic own_pcm;
    logic done;

    assign done     = rom_cs & rom_ok;
    assign pcm_ack  = done & own_pcm;
    assign host_ack = done & ~own_pcm;
    assign rd_data  = rom_data;

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            rom_cs   <= 1'b0;
            own_pcm  <= 1'b0;
            rom_addr <= '0;
        end else if (rom_cs) begin
            // owner is locked until the ROM answers
            if (rom_ok) begin
                rom_cs <= 1'b0;
            end
        end else if (pcm_req) begin
            rom_cs   <= 1'b1;
            own_pcm  <= 1'b1;
            rom_addr <= pcm_addr_req;
        end else if (host_req) begin
            rom_cs   <= 1'b1;
            own_pcm  <= 1'b0;
            rom_addr <= host_addr;
        end
    end

endmodule

/* design/snd_regs.sv */
/* AXI4-Lite slave: one write and one read outstanding at most, only wstrb[0] counts.
   ROM window reads wait on the arbiter, so their rvalid latency varies. */
`timescale 1ns/100ps

module snd_regs (
    input  logic               clk,
    input  logic               comb_rstn,
    input  snd_pkg::axi_addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  snd_pkg::axi_data_t wdata,
    input  logic [3:0]         wstrb,
    input  logic               wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready,
    input  snd_pkg::axi_addr_t araddr,
    input  logic               arvalid,
    output logic               arready,
    output snd_pkg::axi_data_t rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  logic               rready,
    output logic               host_req,
    output snd_pkg::rom_addr_t host_addr,
    input  logic               host_ack,
    input  snd_pkg::rom_byte_t rd_data,
    output logic [1:0]         fx_level,
    output logic               psg_en,
    output logic               fm_en,
    output logic               pcm_en,
    output logic               trigger,
    output snd_pkg::pcm_code_t trigger_code,
    input  logic               busy,
    input  snd_pkg::rom_addr_t pcm_addr,
    input  logic               peak_seen
);
    typedef enum logic [1:0] {rd_idle, rd_rom, rd_resp} rd_state_t;

    rd_state_t          rd_st;
    logic [4:0]         ctrl;
    logic               wr_fire, wr_ctrl, wr_trig, rd_fire, rd_hit, in_window;
    snd_pkg::axi_data_t reg_rdata;

    assign wr_fire   = awready & awvalid & wvalid;
    assign wr_ctrl   = wr_fire && awaddr == snd_pkg::reg_ctrl;
    assign wr_trig   = wr_fire && awaddr == snd_pkg::reg_trigger;
    assign rd_fire   = arready & arvalid;
    assign in_window = araddr[19:16] == snd_pkg::rom_window_base[19:16];
    assign rd_hit    = araddr == snd_pkg::reg_ctrl || araddr == snd_pkg::reg_trigger
                    || araddr == snd_pkg::reg_status;

    // trigger fires in the handshake cycle itself
    assign trigger      = wr_trig & wstrb[0];
    assign trigger_code = wdata[5:0];

    assign fx_level = ctrl[1:0];
    assign psg_en   = ctrl[snd_pkg::ctrl_psg_bit];
    assign fm_en    = ctrl[snd_pkg::ctrl_fm_bit];
    assign pcm_en   = ctrl[snd_pkg::ctrl_pcm_bit];

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= snd_pkg::resp_okay;
            ctrl    <= '0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= (wr_ctrl || wr_trig) ? snd_pkg::resp_okay : snd_pkg::resp_slverr;
                if (wr_ctrl && wstrb[0]) begin
                    ctrl <= wdata[4:0];
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // trigger reads back as zero
    always_comb begin
        reg_rdata = '0;
        if (araddr == snd_pkg::reg_ctrl) begin
            reg_rdata[4:0] = ctrl;
        end else if (araddr == snd_pkg::reg_status) begin
            reg_rdata[snd_pkg::stat_busy_bit] = busy;
            reg_rdata[snd_pkg::stat_peak_bit] = peak_seen;
            reg_rdata[31:16]                  = pcm_addr;
        end
    end

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            rd_st     <= rd_idle;
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            rresp     <= snd_pkg::resp_okay;
            rdata     <= '0;
            host_req  <= 1'b0;
            host_addr <= '0;
        end else begin
            arready <= 1'b0;
            case (rd_st)
                rd_idle: begin
                    arready <= arvalid && !arready;
                    if (rd_fire && in_window) begin
                        host_req  <= 1'b1;
                        host_addr <= araddr[15:0];
                        rd_st     <= rd_rom;
                    end else if (rd_fire) begin
                        rdata  <= reg_rdata;
                        rresp  <= rd_hit ? snd_pkg::resp_okay : snd_pkg::resp_slverr;
                        rvalid <= 1'b1;
                        rd_st  <= rd_resp;
                    end
                end
                rd_rom: begin
                    if (host_ack) begin
                        host_req <= 1'b0;
                        rdata    <= {24'h0, rd_data};
                        rresp    <= snd_pkg::resp_okay;
                        rvalid   <= 1'b1;
                        rd_st    <= rd_resp;
                    end
                end
                default: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        rd_st  <= rd_idle;
                    end
                end
            endcase
        end
    end

endmodule

/* design/snd_pkg.sv */
/* Widths, register map and mixer constants of the sound subsystem.
   All widths are fixed by the board wiring, so nothing here is tunable. */
package snd_pkg;

    typedef logic        [19:0] axi_addr_t;
    typedef logic        [31:0] axi_data_t;
    typedef logic        [15:0] rom_addr_t;
    typedef logic        [ 7:0] rom_byte_t;
    typedef logic        [ 5:0] pcm_code_t;
    // unsigned, 4 fractional bits
    typedef logic        [ 7:0] gain_t;
    typedef logic signed [15:0] audio_t;
    typedef logic        [ 9:0] psg_t;

    typedef enum logic [1:0] {idle, ptr_lo, ptr_hi, play} pcm_state_t;

    // register offsets
    localparam axi_addr_t reg_ctrl        = 20'h0_0000;
    localparam axi_addr_t reg_trigger     = 20'h0_0004;
    localparam axi_addr_t reg_status      = 20'h0_0008;
    localparam axi_addr_t rom_window_base = 20'h1_0000;

    // ctrl holds fx_level in bits 1:0
    localparam int ctrl_psg_bit  = 2;
    localparam int ctrl_fm_bit   = 3;
    localparam int ctrl_pcm_bit  = 4;
    localparam int stat_busy_bit = 0;
    localparam int stat_peak_bit = 1;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    localparam gain_t psg_gain_table [4] = '{8'h03, 8'h06, 8'h08, 8'h0a};
    localparam gain_t fm_gain_solo       = 8'h30;
    localparam gain_t fm_gain_with_pcm   = 8'h20;
    localparam gain_t pcm_gain_on        = 8'h0a;

    // two-byte pointers, low byte first
    localparam rom_addr_t ptr_table_base = 16'h0090;
    localparam int        pcm_tick_div   = 3;

endpackage
